/* design/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit import isa_pkg::*, mem_pkg::*; #(
  parameter int ADDR_W = 8  // PC width
) (
  input  logic               i_clk,
  input  logic               rsta,
  input  logic               i_run,
  output rd_req_t            o_rd,
  input  logic [INSTR_W-1:0] i_rdata,
  input  logic               i_rvalid,
  output instr_out_t         o_instr,
  output logic               o_instr_req,
  input  logic               i_instr_ack,
  output logic               o_halted
);

  typedef enum logic [2:0] {
    F_IDLE    = 3'd0,  // Stopped or halted
    F_ISSUE   = 3'd1,  // Read request on the port
    F_WAIT    = 3'd2,  // Wait for read valid
    F_PRESENT = 3'd3,  // Req high, wait ack
    F_ACK_LOW = 3'd4   // Req low, wait ack to fall
  } fetch_state_e;

  fetch_state_e      state;
  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] pc_nx;
  j_instr_t          word;     // Held word, J-type view
  logic              is_halt;

  assign word    = j_instr_t'(o_instr.instr);
  assign is_halt = (word.opcode == OP_HALT);

  ////////////////////////////////////////
  // Next-PC rule
  ////////////////////////////////////////
  always_comb begin
    if (word.opcode == OP_J) begin
      pc_nx = word.target[ADDR_W-1:0];  // Low bits of the word target
    end else begin
      pc_nx = pc + 1'b1;  // Wraps at the top
    end
  end

  ////////////////////////////////////////
  // Fetch FSM
  ////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (rsta) begin
      state    <= F_IDLE;
      pc       <= '0;
      o_halted <= 1'b0;
    end else begin
      case (state)
        F_IDLE: begin
          if (!i_run) begin
            pc       <= '0;    // Restart from word 0
            o_halted <= 1'b0;  // Halt clears with run
          end else if (!o_halted) begin
            state <= F_ISSUE;
          end
        end
        F_ISSUE: state <= F_WAIT;  // One read only
        F_WAIT: begin
          if (i_rvalid) begin
            state <= F_PRESENT;
          end
        end
        F_PRESENT: begin
          if (i_instr_ack) begin
            state <= F_ACK_LOW;  // Req drops here
          end
        end
        F_ACK_LOW: begin
          if (!i_instr_ack) begin
            pc <= pc_nx;
            if (is_halt) begin
              o_halted <= 1'b1;  // Halt word is out
              state    <= F_IDLE;
            end else if (!i_run) begin
              state <= F_IDLE;
            end else begin
              state <= F_ISSUE;
            end
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  // Payload capture, held for the whole handshake
  always_ff @(posedge i_clk) begin
    if (state == F_WAIT && i_rvalid) begin
      o_instr.instr <= i_rdata;
      o_instr.pc    <= PC_MAX_W'(pc);  // Zero padded
    end
  end

  assign o_rd.en     = (state == F_ISSUE);
  assign o_rd.addr   = MEM_AW'(pc);
  assign o_instr_req = (state == F_PRESENT);

  a_instr_stable: assert property (@(posedge i_clk) disable iff (rsta)
    o_instr_req |=> (!o_instr_req || $stable(o_instr)))
    else $error("o_instr changed while req high");

  // Memory latency and the loader mux keep a single read in flight
  a_one_in_flight: assert property (@(posedge i_clk) disable iff (rsta)
    i_rvalid |-> (state == F_WAIT))
    else $error("read valid outside wait state");

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

  ////////////////////////////////////////
  // Word and field widths
  ////////////////////////////////////////
  localparam int INSTR_W  = 32;  // MIPS instruction word
  localparam int PC_MAX_W = 16;  // Widest PC the out port can carry
  localparam int OPC_W    = 6;   // Major opcode, bits 31:26
  localparam int TGT_W    = 26;  // J-type target field

  // Major opcodes seen by fetch
  // Only OP_J and OP_HALT change the PC flow, the rest run sequential
  typedef enum logic [OPC_W-1:0] {
    OP_SPECIAL = 6'h00,  // R-type group
    OP_J       = 6'h02,  // Jump to target
    OP_BEQ     = 6'h04,  // No branch resolve here
    OP_ADDI    = 6'h08,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b,
    OP_HALT    = 6'h3f   // Reserved code, stops fetch
  } opcode_e;

  // J-type view of an instruction word
  typedef struct packed {
    opcode_e            opcode;  // Bits 31:26
    logic [TGT_W-1:0]   target;  // Word target, bits 25:0
  } j_instr_t;

  ////////////////////////////////////////
  // Instruction out payload
  ////////////////////////////////////////
  typedef struct packed {
    logic [INSTR_W-1:0]  instr;  // Fetched word
    logic [PC_MAX_W-1:0] pc;     // Word address, upper bits zero
  } instr_out_t;

endpackage

/* design/mem_pkg.sv */
package mem_pkg;

  import isa_pkg::*;  // INSTR_W for the data fields

  ////////////////////////////////////////
  // Memory side widths
  ////////////////////////////////////////
  localparam int MEM_AW = 16;  // Address field, low ADDR_W bits used

  // Host load payload
  typedef struct packed {
    logic [MEM_AW-1:0]  addr;  // Word address
    logic [INSTR_W-1:0] data;  // Word to store
  } load_word_t;

  // Single RAM port, driven by the loader
  typedef struct packed {
    logic               en;     // Port enable
    logic               we;     // Write when set, else read
    logic [MEM_AW-1:0]  addr;
    logic [INSTR_W-1:0] wdata;
  } mem_req_t;

  // Read request from fetch
  typedef struct packed {
    logic              en;
    logic [MEM_AW-1:0] addr;
  } rd_req_t;

  ////////////////////////////////////////
  // Loader FSM
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    LD_IDLE      = 3'd0,  // Port belongs to fetch
    LD_WRITE     = 3'd1,  // Host word goes to RAM
    LD_ACK       = 3'd2,  // Load ack high, wait req low
    LD_CLEAR     = 3'd3,  // Sweep running
    LD_CLEAR_ACK = 3'd4   // Clear ack high, wait req low
  } ld_state_e;

endpackage

/* design/mips_fetch_top.sv */
`timescale 1ns/1ns

module mips_fetch_top import isa_pkg::*, mem_pkg::*; #(
  parameter int ADDR_W  = 8,  // 256 words
  parameter int OUT_REG = 1   // Two cycle read
) (
  input  logic       i_clk,
  input  logic       rsta,
  input  logic       i_run,
  input  logic       i_load_req,
  input  load_word_t i_load,
  output logic       o_load_ack,
  input  logic       i_clear_req,
  output logic       o_clear_ack,
  output instr_out_t o_instr,
  output logic       o_instr_req,
  input  logic       i_instr_ack,
  output logic       o_halted
);

  rd_req_t            rd;          // Fetch to loader
  mem_req_t           mem;         // Loader to RAM port
  logic               mem_clear;
  logic               clear_done;
  logic [INSTR_W-1:0] rdata;       // RAM straight to fetch
  logic               rvalid;

  ////////////////////////////////////////
  // Port owner
  ////////////////////////////////////////
  program_loader #(.ADDR_W(ADDR_W)) u_loader (
    .i_clk       (i_clk),
    .rsta        (rsta),
    .i_run       (i_run),
    .i_load_req  (i_load_req),
    .i_load      (i_load),
    .o_load_ack  (o_load_ack),
    .i_clear_req (i_clear_req),
    .o_clear_ack (o_clear_ack),
    .i_rd        (rd),
    .o_mem       (mem),
    .o_clear     (mem_clear),
    .i_clear_done(clear_done)
  );

  program_memory #(.ADDR_W(ADDR_W), .OUT_REG(OUT_REG)) u_mem (
    .i_clk       (i_clk),
    .rsta        (rsta),
    .i_mem       (mem),
    .i_clear     (mem_clear),
    .o_rdata     (rdata),
    .o_rvalid    (rvalid),
    .o_clear_done(clear_done)
  );

  fetch_unit #(.ADDR_W(ADDR_W)) u_fetch (
    .i_clk       (i_clk),
    .rsta        (rsta),
    .i_run       (i_run),
    .o_rd        (rd),
    .i_rdata     (rdata),
    .i_rvalid    (rvalid),
    .o_instr     (o_instr),
    .o_instr_req (o_instr_req),
    .i_instr_ack (i_instr_ack),
    .o_halted    (o_halted)
  );

endmodule

/* design/program_loader.sv */
`timescale 1ns/1ns

module program_loader import mem_pkg::*; #(
  parameter int ADDR_W = 8  // Used address bits
) (
  input  logic       i_clk,
  input  logic       rsta,
  input  logic       i_run,
  input  logic       i_load_req,
  input  load_word_t i_load,
  output logic       o_load_ack,
  input  logic       i_clear_req,
  output logic       o_clear_ack,
  input  rd_req_t    i_rd,
  output mem_req_t   o_mem,
  output logic       o_clear,
  input  logic       i_clear_done
);

  ld_state_e state;
  ld_state_e state_nx;

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (rsta) begin
      state <= LD_IDLE;
    end else begin
      state <= state_nx;
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      LD_IDLE: begin
        // Host requests only while fetch is stopped
        if (!i_run) begin
          if (i_load_req) begin
            state_nx = LD_WRITE;  // Load wins a tie
          end else if (i_clear_req) begin
            state_nx = LD_CLEAR;
          end
        end
      end
      LD_WRITE: state_nx = LD_ACK;  // Write lands this edge
      LD_ACK: begin
        if (!i_load_req) begin
          state_nx = LD_IDLE;  // Ack drops with the state
        end
      end
      LD_CLEAR: begin
        if (i_clear_done) begin
          state_nx = LD_CLEAR_ACK;
        end
      end
      LD_CLEAR_ACK: begin
        if (!i_clear_req) begin
          state_nx = LD_IDLE;
        end
      end
      default: state_nx = LD_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Memory port mux
  ////////////////////////////////////////
  always_comb begin
    o_mem = '0;
    case (state)
      LD_IDLE: begin
        o_mem.en   = i_rd.en;  // Fetch read passes through
        o_mem.addr = MEM_AW'(i_rd.addr[ADDR_W-1:0]);
      end
      LD_WRITE: begin
        o_mem.en    = 1'b1;
        o_mem.we    = 1'b1;
        o_mem.addr  = MEM_AW'(i_load.addr[ADDR_W-1:0]);
        o_mem.wdata = i_load.data;  // Host holds it until ack
      end
      default: o_mem = '0;  // Port quiet during ack and sweep
    endcase
  end

  assign o_load_ack  = (state == LD_ACK);
  assign o_clear_ack = (state == LD_CLEAR_ACK);
  assign o_clear     = (state == LD_CLEAR);  // Memory sweeps while high

  // An ack only answers a live req
  a_load_ack_req: assert property (@(posedge i_clk) disable iff (rsta)
    $rose(o_load_ack) |-> i_load_req)
    else $error("load ack without req");

  a_clear_ack_req: assert property (@(posedge i_clk) disable iff (rsta)
    $rose(o_clear_ack) |-> i_clear_req)
    else $error("clear ack without req");

  // Fetch keeps the port while running
  a_no_accept_in_run: assert property (@(posedge i_clk) disable iff (rsta)
    i_run |-> (state == LD_IDLE))
    else $error("host request accepted while running");

endmodule

/* design/program_memory.sv */
`timescale 1ns/1ns

module program_memory import isa_pkg::*, mem_pkg::*; #(
  parameter int ADDR_W  = 8,  // 2**ADDR_W words
  parameter int OUT_REG = 1   // 1 adds the output register
) (
  input  logic               i_clk,
  input  logic               rsta,
  input  mem_req_t           i_mem,
  input  logic               i_clear,
  output logic [INSTR_W-1:0] o_rdata,
  output logic               o_rvalid,
  output logic               o_clear_done
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [INSTR_W-1:0] ram [DEPTH];  // Block RAM array
  logic [INSTR_W-1:0] rd_q;         // RAM read register
  logic [OUT_REG:0]   vld_q;        // Read-valid pipeline, one stage per read cycle
  logic [ADDR_W-1:0]  sweep_cnt;    // Word being zeroed
  logic               sweep_done;
  logic               rd_fire;
  logic               wr_fire;
  logic [ADDR_W-1:0]  addr;

  assign addr    = i_mem.addr[ADDR_W-1:0];  // Upper address bits ignored
  assign rd_fire = i_mem.en & ~i_mem.we & ~i_clear;
  assign wr_fire = i_mem.en &  i_mem.we & ~i_clear;  // Clear owns the port

  // Power-up contents, the loader fills the rest
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      ram[i] = '0;
    end
  end

  ////////////////////////////////////////
  // Soft clear sweep
  ////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (rsta) begin
      sweep_cnt  <= '0;
      sweep_done <= 1'b0;
    end else if (!i_clear) begin
      sweep_cnt  <= '0;    // Rearm for the next clear
      sweep_done <= 1'b0;  // Done drops with clear
    end else if (!sweep_done) begin
      sweep_cnt <= sweep_cnt + 1'b1;  // One word per cycle
      if (sweep_cnt == ADDR_W'(DEPTH - 1)) begin
        sweep_done <= 1'b1;  // Last word written this edge
      end
    end
  end

  // RAM port, sweep has priority over normal access
  always @(posedge i_clk) begin
    if (i_clear) begin
      if (!sweep_done) begin
        ram[sweep_cnt] <= '0;
      end
    end else if (wr_fire) begin
      ram[addr] <= i_mem.wdata;
    end
    if (rd_fire) begin
      rd_q <= ram[addr];  // First read stage
    end
  end

  ////////////////////////////////////////
  // Read latency
  ////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (rsta) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= rd_fire;
      for (int i = 1; i <= OUT_REG; i++) begin
        vld_q[i] <= vld_q[i-1];  // Follows the data stages
      end
    end
  end

  generate
    if (OUT_REG != 0) begin : g_out_reg
      logic [INSTR_W-1:0] out_q;  // Second stage, better clock-to-out

      always_ff @(posedge i_clk) begin
        if (vld_q[0]) begin
          out_q <= rd_q;
        end
      end

      assign o_rdata = out_q;
    end else begin : g_no_out_reg
      assign o_rdata = rd_q;  // Single cycle read
    end
  endgenerate

  assign o_rvalid     = vld_q[OUT_REG];
  assign o_clear_done = sweep_done;  // Held until clear falls

  // Loader must keep writes off the port during a sweep
  a_no_wr_in_clear: assert property (@(posedge i_clk) disable iff (rsta)
    i_clear |-> !(i_mem.en && i_mem.we))
    else $error("write issued during clear sweep");

endmodule

/* sim.f */
design/isa_pkg.sv
design/mem_pkg.sv
design/program_memory.sv
design/program_loader.sv
design/fetch_unit.sv
design/mips_fetch_top.sv
testbench/tb_mips_fetch.sv

/* testbench/tb_mips_fetch.sv */
`timescale 1ns/1ns

module tb_mips_fetch import isa_pkg::*, mem_pkg::*; ();

  localparam int          TMO      = 50;            // Handshake wait limit in cycles
  localparam int          CLR_TMO  = 400;           // Sweep needs 256 cycles
  localparam logic [31:0] SEED     = 32'h35b4;
  localparam logic [31:0] TAPS     = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
  localparam int          SEL_LOAD = 0;             // Selectors for wait_level
  localparam int          SEL_CLR  = 1;
  localparam int          SEL_REQ  = 2;
  localparam int          SEL_HALT = 3;

  logic       i_clk;
  logic       rsta;
  logic       i_run;
  logic       i_load_req;
  load_word_t i_load;
  logic       o_load_ack;
  logic       i_clear_req;
  logic       o_clear_ack;
  instr_out_t o_instr;
  logic       o_instr_req;
  logic       i_instr_ack;
  logic       o_halted;

  logic [31:0] lfsr_q;
  logic [31:0] model_mem [256];  // Mirror of the program RAM
  logic [31:0] exp_instr [$];    // Predicted stream
  logic [7:0]  exp_pc [$];
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  bit          aborted;          // Set on a timeout so later waits return at once

  mips_fetch_top #(.ADDR_W(8), .OUT_REG(1)) dut (
    .i_clk      (i_clk),
    .rsta       (rsta),
    .i_run      (i_run),
    .i_load_req (i_load_req),
    .i_load     (i_load),
    .o_load_ack (o_load_ack),
    .i_clear_req(i_clear_req),
    .o_clear_ack(o_clear_ack),
    .o_instr    (o_instr),
    .o_instr_req(o_instr_req),
    .i_instr_ack(i_instr_ack),
    .o_halted   (o_halted)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;  // 100 ns period
  end

  ////////////////////////////////////////
  // Random source and model
  ////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};  // One LFSR step per bit
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic bit is_halt(input logic [31:0] word);
    return word[31:26] == OP_HALT;
  endfunction

  function automatic logic [7:0] next_pc(input logic [7:0] pc, input logic [31:0] word);
    logic [7:0] nx;
    if (word[31:26] == OP_J) begin
      nx = word[7:0];  // Low bits of the jump target
    end else begin
      nx = pc + 8'd1;  // Wraps after 255
    end
    return nx;
  endfunction

  // Half the words jump and none halt
  function automatic logic [31:0] random_word();
    logic [1:0]  pick;
    logic [5:0]  opc;
    logic [25:0] rest;
    pick = 2'(rand_bits(2));
    case (pick)
      2'd0, 2'd1: opc = OP_J;
      2'd2:       opc = OP_SPECIAL;
      default: begin
        opc = 6'(rand_bits(6));
        if (opc == OP_HALT) begin
          opc = OP_ADDI;
        end
      end
    endcase
    rest = 26'(rand_bits(26));
    return {opc, rest};
  endfunction

  ////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
    end
  endtask

  function automatic logic sig_now(input int sel);
    case (sel)
      SEL_LOAD: return o_load_ack;
      SEL_CLR:  return o_clear_ack;
      SEL_REQ:  return o_instr_req;
      default:  return o_halted;
    endcase
  endfunction

  // Sampled at the rising edge before the DUT updates
  task automatic wait_level(input int sel, input logic level, input int limit,
                            input string what);
    int n;
    n = 0;
    if (!aborted) begin
      @(posedge i_clk);
      while (sig_now(sel) !== level && n < limit) begin
        @(posedge i_clk);
        n++;
      end
      if (sig_now(sel) !== level) begin
        err_cnt++;
        aborted = 1'b1;
        $display("Timeout: %s did not go to %0d within %0d cycles", what, level, limit);
      end
    end
  endtask

  ////////////////////////////////////////
  // Host and consumer handshakes
  ////////////////////////////////////////
  task automatic load_word(input logic [7:0] addr, input logic [31:0] data);
    @(posedge i_clk);
    i_load.addr <= 16'(addr);
    i_load.data <= data;
    i_load_req  <= 1'b1;
    wait_level(SEL_LOAD, 1'b1, TMO, "o_load_ack");
    i_load_req <= 1'b0;
    wait_level(SEL_LOAD, 1'b0, TMO, "o_load_ack");
    model_mem[addr] = data;
  endtask

  task automatic take_instr(input int delay_max, output instr_out_t got);
    int d;
    wait_level(SEL_REQ, 1'b1, TMO, "o_instr_req");
    got = o_instr;  // Held stable while req is high
    d = (delay_max > 0) ? int'(rand_bits(3)) : 0;
    repeat (d) @(posedge i_clk);
    i_instr_ack <= 1'b1;
    wait_level(SEL_REQ, 1'b0, TMO, "o_instr_req");
    i_instr_ack <= 1'b0;
  endtask

  // Ack whatever word is still in flight after run drops
  task automatic drain_fetch();
    for (int i = 0; i < 16; i++) begin
      @(posedge i_clk);
      if (o_instr_req) begin
        i_instr_ack <= 1'b1;
        wait_level(SEL_REQ, 1'b0, TMO, "o_instr_req");
        i_instr_ack <= 1'b0;
      end
    end
  endtask

  task automatic predict_stream();
    logic [7:0] pc;
    bit         done;
    exp_instr.delete();
    exp_pc.delete();
    pc   = '0;
    done = 1'b0;
    while (!done && exp_pc.size() < 512) begin
      exp_pc.push_back(pc);
      exp_instr.push_back(model_mem[pc]);
      done = is_halt(model_mem[pc]);  // Halt word is still delivered
      pc   = next_pc(pc, model_mem[pc]);
    end
  endtask

  // Random words and then a halt somewhere on the walk from PC 0
  task automatic build_program(input int n_words);
    logic [7:0]  pc;
    logic [31:0] word;
    int          steps;
    for (int i = 0; i < n_words; i++) begin
      word = random_word();
      load_word(8'(rand_bits(8)), word);
    end
    steps = int'(rand_bits(6));
    pc    = '0;
    for (int s = 0; s < steps && !is_halt(model_mem[pc]); s++) begin
      pc = next_pc(pc, model_mem[pc]);
    end
    word = {OP_HALT, 26'(rand_bits(26))};
    load_word(pc, word);
    predict_stream();
  endtask

  task automatic run_program(input int delay_max, input string label);
    instr_out_t got;
    int         errs_at_start;
    errs_at_start = err_cnt;
    @(posedge i_clk);
    i_run <= 1'b1;
    for (int i = 0; i < exp_pc.size() && !aborted; i++) begin
      take_instr(delay_max, got);
      if (!aborted) begin
        check_val("o_instr.instr", exp_instr[i], got.instr);
        check_val("o_instr.pc", 32'(exp_pc[i]), 32'(got.pc));
      end
    end
    wait_level(SEL_HALT, 1'b1, TMO, "o_halted");
    for (int i = 0; i < 8; i++) begin
      @(posedge i_clk);
      check_val("o_instr_req", 32'd0, 32'(o_instr_req));  // Nothing past the halt
    end
    @(posedge i_clk);
    i_run <= 1'b0;
    wait_level(SEL_HALT, 1'b0, TMO, "o_halted");
    test_cnt++;
    $display("%s: %0d words, %0d errors", label, exp_pc.size(), err_cnt - errs_at_start);
  endtask

  task automatic clear_and_sweep();
    instr_out_t got;
    int         errs_at_start;
    errs_at_start = err_cnt;
    @(posedge i_clk);
    i_clear_req <= 1'b1;
    wait_level(SEL_CLR, 1'b1, CLR_TMO, "o_clear_ack");
    i_clear_req <= 1'b0;
    wait_level(SEL_CLR, 1'b0, TMO, "o_clear_ack");
    for (int a = 0; a < 256; a++) begin
      model_mem[a] = '0;
    end
    i_run <= 1'b1;
    for (int i = 0; i < 300 && !aborted; i++) begin
      take_instr(0, got);
      if (!aborted) begin
        check_val("o_instr.instr", 32'd0, got.instr);
        check_val("o_instr.pc", 32'(i % 256), 32'(got.pc));
      end
    end
    @(posedge i_clk);
    i_run <= 1'b0;
    drain_fetch();
    test_cnt++;
    $display("Test 4 clear and sweep: 300 words, %0d errors", err_cnt - errs_at_start);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    rsta        = 1'b1;
    i_run       = 1'b0;
    i_load_req  = 1'b0;
    i_load      = '0;
    i_clear_req = 1'b0;
    i_instr_ack = 1'b0;
    lfsr_q      = SEED;
    err_cnt     = 0;
    check_cnt   = 0;
    test_cnt    = 0;
    aborted     = 1'b0;
    for (int a = 0; a < 256; a++) begin
      model_mem[a] = '0;  // RAM powers up zeroed
    end
    repeat (5) @(posedge i_clk);
    rsta <= 1'b0;

    @(posedge i_clk);
    check_val("o_load_ack", 32'd0, 32'(o_load_ack));
    check_val("o_clear_ack", 32'd0, 32'(o_clear_ack));
    check_val("o_instr_req", 32'd0, 32'(o_instr_req));
    check_val("o_halted", 32'd0, 32'(o_halted));
    test_cnt++;
    $display("Test 1 reset state: %0d errors", err_cnt);

    build_program(40);
    run_program(0, "Test 2 random program");
    build_program(40);
    run_program(7, "Test 3 random program, slow consumer");
    clear_and_sweep();
    build_program(4);
    run_program(7, "Test 5 sparse program after clear");

    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
